// File: include/cp15_cfg.svh
`ifndef CP15_CFG_SVH
`define CP15_CFG_SVH

// ************************************************************
// Register file geometry
// ************************************************************

`define CP15_NUM_REGS   16
`define CP15_DATA_W     32

// Fixed identification word returned by c0
`define CP15_ID_VALUE   32'h4401_A150

// ************************************************************
// Register numbers with special meaning
// ************************************************************

`define CP15_REG_CTRL   1
`define CP15_REG_TBASE  2
`define CP15_REG_CACHE  7
`define CP15_REG_TLB    8

// Requester tags carried in the src field
`define CP15_SRC_CPU    1'b0
`define CP15_SRC_MMU    1'b1

`endif

// File: logic/cp15_pkg.sv
`include "cp15_cfg.svh"

package cp15_pkg;

  // ************************************************************
  // Request and response words
  // ************************************************************

  // One coprocessor register transfer that is an MCR when write is set
  typedef struct packed {
    logic                    write;
    logic                    src;
    logic [3:0]              crn;
    logic [2:0]              opcode2;
    logic [3:0]              crm;
    logic [`CP15_DATA_W-1:0] wdata;
  } cp15Req_t;

  // Read data back to whichever requester issued the MRC
  typedef struct packed {
    logic                    src;
    logic [`CP15_DATA_W-1:0] rdata;
  } cp15Rsp_t;

  // ************************************************************
  // Maintenance pulses from c7 and c8 writes
  // ************************************************************

  typedef struct packed {
    logic flushI;
    logic flushD;
    logic cleanI;
    logic cleanD;
    logic tlbFlushI;
    logic tlbFlushD;
  } cp15MaintOps_t;

  // ************************************************************
  // Control register (c1)
  // ************************************************************

  // Field layout from the MSB down
  typedef struct packed {
    logic [17:0] rsvdHigh;
    logic        highVectors;
    logic        iCacheEnable;
    logic [7:0]  rsvdMid;
    logic        writeBuffer;
    logic        dCacheEnable;
    logic        alignCheck;
    logic        mmuEnable;
  } cp15CtrlBits_t;

  // Same word seen raw or as named bits
  typedef union packed {
    logic [`CP15_DATA_W-1:0] raw;
    cp15CtrlBits_t           bits;
  } cp15Ctrl_u;

endpackage

// File: logic/cp15Arbiter.sv
`include "cp15_cfg.svh"

module cp15Arbiter (
  input  logic               clk,
  input  logic               reset,
  input  logic               cpuReqValid,
  input  logic               mmuReqValid,
  input  cp15_pkg::cp15Req_t cpuReq,
  input  cp15_pkg::cp15Req_t mmuReq,
  output logic               cpuReqReady,
  output logic               mmuReqReady,
  output logic               stage1Valid,
  output cp15_pkg::cp15Req_t stage1Req
);

  import cp15_pkg::*;

  logic     cpuFire;
  logic     mmuFire;
  cp15Req_t granted;

  // ************************************************************
  // Request acceptance
  // ************************************************************

  // Stage 1 hands off every cycle and the MMU holds off the CPU while it presents
  assign mmuReqReady = 1'b1;
  assign cpuReqReady = ~mmuReqValid;

  assign mmuFire = mmuReqValid & mmuReqReady;
  assign cpuFire = cpuReqValid & cpuReqReady;

  // Pick the winner and stamp its source
  always_comb begin
    if (mmuFire) begin
      granted     = mmuReq;
      granted.src = `CP15_SRC_MMU;
    end else begin
      granted     = cpuReq;
      granted.src = `CP15_SRC_CPU;
    end
  end

  // ************************************************************
  // Stage 1 register
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      stage1Valid <= 1'b0;
    end else begin
      stage1Valid <= cpuFire | mmuFire;
    end
  end

  // Payload only loads on an accepted transfer
  always_ff @(posedge clk) begin
    if (cpuFire | mmuFire) begin
      stage1Req <= granted;
    end
  end

endmodule

// File: logic/cp15RegFile.sv
`include "cp15_cfg.svh"

module cp15RegFile (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stage1Valid,
  input  cp15_pkg::cp15Req_t      stage1Req,
  output logic                    rspValid,
  output cp15_pkg::cp15Rsp_t      rsp,
  output cp15_pkg::cp15Ctrl_u     control,
  output logic [`CP15_DATA_W-1:0] tbase
);

  // c0 has no storage and reads back the ID word
  logic [`CP15_DATA_W-1:0] rf [1:`CP15_NUM_REGS-1];

  logic                    writeEn;
  logic                    readEn;
  logic                    isIdReg;
  logic [`CP15_DATA_W-1:0] readData;

  // ************************************************************
  // Request decode
  // ************************************************************

  assign isIdReg = (stage1Req.crn == 4'd0);

  // Writes to c0 are silently dropped
  assign writeEn = stage1Valid & stage1Req.write & ~isIdReg;
  assign readEn  = stage1Valid & ~stage1Req.write;

  always_comb begin
    if (isIdReg) begin
      readData = `CP15_ID_VALUE;
    end else begin
      readData = rf[stage1Req.crn];
    end
  end

  // ************************************************************
  // Register storage
  // ************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < `CP15_NUM_REGS; i++) begin
        rf[i] <= '0;
      end
    end else if (writeEn) begin
      rf[stage1Req.crn] <= stage1Req.wdata;
    end
  end

  // ************************************************************
  // Read response
  // ************************************************************

  // Only reads produce a response
  always_ff @(posedge clk) begin
    if (reset) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= readEn;
    end
  end

  always_ff @(posedge clk) begin
    if (readEn) begin
      rsp.src   <= stage1Req.src;
      rsp.rdata <= readData;
    end
  end

  // Control and translation base are always visible
  assign control.raw = rf[`CP15_REG_CTRL];
  assign tbase       = rf[`CP15_REG_TBASE];

endmodule

// File: logic/cp15MaintDecode.sv
`include "cp15_cfg.svh"

module cp15MaintDecode (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stage1Valid,
  input  cp15_pkg::cp15Req_t      stage1Req,
  output cp15_pkg::cp15MaintOps_t maintOps
);

  import cp15_pkg::*;

  logic          opWrite;
  logic          hitCache;
  logic          hitTlb;
  cp15MaintOps_t opsNext;

  // ************************************************************
  // Qualify the request
  // ************************************************************

  // opcode2 of 0 and 1 decode the same way
  assign opWrite  = stage1Valid & stage1Req.write & (stage1Req.opcode2[2:1] == 2'b00);
  assign hitCache = opWrite & (stage1Req.crn == 4'(`CP15_REG_CACHE));
  assign hitTlb   = opWrite & (stage1Req.crn == 4'(`CP15_REG_TLB));

  // ************************************************************
  // c7 / c8 decode tables
  // ************************************************************

  always_comb begin
    opsNext = '0;

    if (hitCache) begin
      // {flushI, flushD, cleanI, cleanD}
      case (stage1Req.crm)
        4'd7:    {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b1100;
        4'd5:    {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b1000;
        4'd6:    {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b0100;
        4'd11:   {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b0011;
        4'd10:   {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b0001;
        4'd15:   {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b1111;
        4'd14:   {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b0101;
        default: {opsNext.flushI, opsNext.flushD, opsNext.cleanI, opsNext.cleanD} = 4'b0000;
      endcase
    end

    if (hitTlb) begin
      // {tlbFlushI, tlbFlushD}
      case (stage1Req.crm)
        4'd7:    {opsNext.tlbFlushI, opsNext.tlbFlushD} = 2'b11;
        4'd5:    {opsNext.tlbFlushI, opsNext.tlbFlushD} = 2'b10;
        4'd6:    {opsNext.tlbFlushI, opsNext.tlbFlushD} = 2'b01;
        default: {opsNext.tlbFlushI, opsNext.tlbFlushD} = 2'b00;
      endcase
    end
  end

  // One-cycle pulse that lands with the register write
  always_ff @(posedge clk) begin
    if (reset) begin
      maintOps <= '0;
    end else begin
      maintOps <= opsNext;
    end
  end

endmodule

// File: logic/cp15Top.sv
`include "cp15_cfg.svh"

module cp15Top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cpuReqValid,
  input  cp15_pkg::cp15Req_t      cpuReq,
  output logic                    cpuReqReady,
  input  logic                    mmuReqValid,
  input  cp15_pkg::cp15Req_t      mmuReq,
  output logic                    mmuReqReady,
  output logic                    rspValid,
  output cp15_pkg::cp15Rsp_t      rsp,
  output cp15_pkg::cp15Ctrl_u     control,
  output logic [`CP15_DATA_W-1:0] tbase,
  output cp15_pkg::cp15MaintOps_t maintOps
);

  import cp15_pkg::*;

  // Granted request shared by both back-end blocks
  logic     stage1Valid;
  cp15Req_t stage1Req;

  cp15Arbiter arbiter (
    .clk         (clk),
    .reset       (reset),
    .cpuReqValid (cpuReqValid),
    .mmuReqValid (mmuReqValid),
    .cpuReq      (cpuReq),
    .mmuReq      (mmuReq),
    .cpuReqReady (cpuReqReady),
    .mmuReqReady (mmuReqReady),
    .stage1Valid (stage1Valid),
    .stage1Req   (stage1Req)
  );

  cp15RegFile regFile (
    .clk         (clk),
    .reset       (reset),
    .stage1Valid (stage1Valid),
    .stage1Req   (stage1Req),
    .rspValid    (rspValid),
    .rsp         (rsp),
    .control     (control),
    .tbase       (tbase)
  );

  // Runs alongside the register file on the same stage
  cp15MaintDecode maintDecode (
    .clk         (clk),
    .reset       (reset),
    .stage1Valid (stage1Valid),
    .stage1Req   (stage1Req),
    .maintOps    (maintOps)
  );

endmodule

// File: verif/cp15Checker.sv
`include "cp15_cfg.svh"

module cp15Checker (
  input logic                    clk,
  input logic                    reset,
  input logic                    cpuReqValid,
  input cp15_pkg::cp15Req_t      cpuReq,
  input logic                    cpuReqReady,
  input logic                    mmuReqValid,
  input cp15_pkg::cp15Req_t      mmuReq,
  input logic                    mmuReqReady,
  input logic                    rspValid,
  input cp15_pkg::cp15Rsp_t      rsp,
  input cp15_pkg::cp15Ctrl_u     control,
  input logic [`CP15_DATA_W-1:0] tbase,
  input cp15_pkg::cp15MaintOps_t maintOps
);

  timeunit 1ns;
  timeprecision 100ps;

  import cp15_pkg::*;

  // Register model with the c0 entry unused
  logic [`CP15_DATA_W-1:0] model [0:`CP15_NUM_REGS-1];

  // Expected outputs indexed by cycle modulo 4
  logic                    expRspValid [0:3];
  cp15Rsp_t                expRsp      [0:3];
  cp15MaintOps_t           expMaint    [0:3];

  // Model view of c1 and c2 delayed to the output timing
  logic [`CP15_DATA_W-1:0] ctrlPipe    [0:1];
  logic [`CP15_DATA_W-1:0] tbasePipe   [0:1];

  int    cycle;
  string testName = "startup";
  int    errorCount;
  int    checkCount;
  int    testCount;
  int    testErrBase;
  int    cpuAccepts;
  int    mmuAccepts;

  task automatic compareWord(string what, logic [31:0] expected, logic [31:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("MISMATCH %s %s: expected %h actual %h", testName, what, expected, actual);
    end
  endtask

  // ************************************************************
  // Maintenance decode tables for c7 and c8
  // ************************************************************

  // Bit order {flushI, flushD, cleanI, cleanD, tlbFlushI, tlbFlushD}
  function automatic cp15MaintOps_t expectedOps(cp15Req_t r);
    logic [5:0] ops;
    ops = 6'b000000;
    if (r.write && r.opcode2 < 3'd2 && r.crn == 4'(`CP15_REG_CACHE)) begin
      case (r.crm)
        4'd7:    ops = 6'b110000;
        4'd5:    ops = 6'b100000;
        4'd6:    ops = 6'b010000;
        4'd11:   ops = 6'b001100;
        4'd10:   ops = 6'b000100;
        4'd15:   ops = 6'b111100;
        4'd14:   ops = 6'b010100;
        default: ops = 6'b000000;
      endcase
    end else if (r.write && r.opcode2 < 3'd2 && r.crn == 4'(`CP15_REG_TLB)) begin
      case (r.crm)
        4'd7:    ops = 6'b000011;
        4'd5:    ops = 6'b000010;
        4'd6:    ops = 6'b000001;
        default: ops = 6'b000000;
      endcase
    end
    return cp15MaintOps_t'(ops);
  endfunction

  // Apply one accepted request to the model and schedule its outputs
  task automatic acceptRequest(cp15Req_t r, int due);
    if (r.write) begin
      if (r.crn != 4'd0) begin
        model[r.crn] = r.wdata;
      end
    end else begin
      expRspValid[due]  = 1'b1;
      expRsp[due].src   = r.src;
      expRsp[due].rdata = (r.crn == 4'd0) ? `CP15_ID_VALUE : model[r.crn];
    end
    expMaint[due] = expectedOps(r);
  endtask

  // ************************************************************
  // Per-cycle comparison
  // ************************************************************

  always @(posedge clk) begin : sampleEdge
    int       slot;
    cp15Req_t acc;
    if (reset) begin
      for (int i = 0; i < `CP15_NUM_REGS; i++) begin
        model[i] = '0;
      end
      for (int i = 0; i < 4; i++) begin
        expRspValid[i] = 1'b0;
        expMaint[i]    = '0;
      end
      ctrlPipe[0]  = '0;
      ctrlPipe[1]  = '0;
      tbasePipe[0] = '0;
      tbasePipe[1] = '0;
      cycle        = 0;
    end else begin
      slot = cycle % 4;
      compareWord("rspValid", 32'(expRspValid[slot]), 32'(rspValid));
      if (expRspValid[slot] && rspValid) begin
        compareWord("rsp src", 32'(expRsp[slot].src), 32'(rsp.src));
        compareWord("rsp data", expRsp[slot].rdata, rsp.rdata);
      end
      compareWord("maintOps", 32'(expMaint[slot]), 32'(maintOps));
      compareWord("control", ctrlPipe[1], control.raw);
      compareWord("control bits",
                  {26'd0, ctrlPipe[1][13], ctrlPipe[1][12], ctrlPipe[1][3:0]},
                  {26'd0, control.bits.highVectors, control.bits.iCacheEnable,
                   control.bits.writeBuffer, control.bits.dCacheEnable,
                   control.bits.alignCheck, control.bits.mmuEnable});
      compareWord("tbase", tbasePipe[1], tbase);

      // The MMU is never held off and always blocks the CPU
      if (!mmuReqReady) begin
        errorCount++;
        $display("%s: MMU port was not ready at cycle %0d", testName, cycle);
      end
      if (mmuReqValid && cpuReqReady) begin
        errorCount++;
        $display("%s: CPU port was ready while the MMU request was pending", testName);
      end

      expRspValid[slot] = 1'b0;
      expMaint[slot]    = '0;
      ctrlPipe[1]       = ctrlPipe[0];
      tbasePipe[1]      = tbasePipe[0];

      if (mmuReqValid && mmuReqReady) begin
        acc     = mmuReq;
        acc.src = `CP15_SRC_MMU;
        mmuAccepts++;
        acceptRequest(acc, (cycle + 2) % 4);
      end else if (cpuReqValid && cpuReqReady) begin
        acc     = cpuReq;
        acc.src = `CP15_SRC_CPU;
        cpuAccepts++;
        acceptRequest(acc, (cycle + 2) % 4);
      end

      ctrlPipe[0]  = model[`CP15_REG_CTRL];
      tbasePipe[0] = model[`CP15_REG_TBASE];
      cycle++;
    end
  end

  // ************************************************************
  // Test bookkeeping
  // ************************************************************

  task startTest(string name);
    testName    = name;
    testErrBase = errorCount;
    cpuAccepts  = 0;
    mmuAccepts  = 0;
  endtask

  // Accept counts catch a lost or duplicated request
  task endTest(int expCpu, int expMmu);
    compareWord("cpu accepts", 32'(expCpu), 32'(cpuAccepts));
    compareWord("mmu accepts", 32'(expMmu), 32'(mmuAccepts));
    testCount++;
    $display("Test %-12s finished with %0d errors", testName, errorCount - testErrBase);
  endtask

endmodule

// File: verif/cp15Tb.sv
`include "cp15_cfg.svh"

module cp15Tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cp15_pkg::*;

  localparam int CLK_PERIOD     = 10;
  localparam int RESET_CYCLES   = 4;
  localparam int MAX_GAP        = 3;

  // Requests per test
  localparam int RESET_REQS     = 5;
  localparam int RAND_REQS      = 40;
  localparam int CTRL_CPU_REQS  = 24;
  localparam int CTRL_MMU_REQS  = 8;
  localparam int COLL_REQS      = 20;
  localparam int MAINT_REQS     = 40;
  localparam int B2B_REQS       = 40;
  localparam int TOTAL_REQS     = RESET_REQS + 2 * RAND_REQS + CTRL_CPU_REQS + CTRL_MMU_REQS
                                  + 2 * COLL_REQS + 2 * MAINT_REQS + B2B_REQS;

  // Gap, handshake and a stall behind the MMU with room to spare
  localparam int CYCLES_PER_REQ = 12;
  localparam int WATCHDOG_NS    = (TOTAL_REQS * CYCLES_PER_REQ + RESET_CYCLES + 100) * CLK_PERIOD;

  logic                    clk;
  logic                    reset;
  logic                    cpuReqValid;
  cp15Req_t                cpuReq;
  logic                    cpuReqReady;
  logic                    mmuReqValid;
  cp15Req_t                mmuReq;
  logic                    mmuReqReady;
  logic                    rspValid;
  cp15Rsp_t                rsp;
  cp15Ctrl_u               control;
  logic [`CP15_DATA_W-1:0] tbase;
  cp15MaintOps_t           maintOps;

  integer   seed = 32'he0c1_6a89;
  cp15Req_t cpuQ[$];
  cp15Req_t mmuQ[$];
  int       cpuGapQ[$];
  int       mmuGapQ[$];

  cp15Top UUT (
    .clk         (clk),
    .reset       (reset),
    .cpuReqValid (cpuReqValid),
    .cpuReq      (cpuReq),
    .cpuReqReady (cpuReqReady),
    .mmuReqValid (mmuReqValid),
    .mmuReq      (mmuReq),
    .mmuReqReady (mmuReqReady),
    .rspValid    (rspValid),
    .rsp         (rsp),
    .control     (control),
    .tbase       (tbase),
    .maintOps    (maintOps)
  );

  cp15Checker chk (
    .clk         (clk),
    .reset       (reset),
    .cpuReqValid (cpuReqValid),
    .cpuReq      (cpuReq),
    .cpuReqReady (cpuReqReady),
    .mmuReqValid (mmuReqValid),
    .mmuReq      (mmuReq),
    .mmuReqReady (mmuReqReady),
    .rspValid    (rspValid),
    .rsp         (rsp),
    .control     (control),
    .tbase       (tbase),
    .maintOps    (maintOps)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the requests did not complete", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  // ************************************************************
  // Stimulus helpers
  // ************************************************************

  function automatic int pickBelow(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic cp15Req_t makeReq(logic wr, logic [3:0] crn, logic [2:0] op2,
                                       logic [3:0] crm);
    cp15Req_t r;
    r.write   = wr;
    r.src     = 1'(pickBelow(2));
    r.crn     = crn;
    r.opcode2 = op2;
    r.crm     = crm;
    r.wdata   = $random(seed);
    return r;
  endfunction

  task automatic queueReq(logic toMmu, cp15Req_t r, int gap);
    if (toMmu) begin
      mmuQ.push_back(r);
      mmuGapQ.push_back(gap);
    end else begin
      cpuQ.push_back(r);
      cpuGapQ.push_back(gap);
    end
  endtask

  // Any register with a random direction, opcode2 and crm
  task automatic fillRandom(logic toMmu, int count, int maxGap);
    logic       wr;
    logic [3:0] crn;
    logic [2:0] op2;
    logic [3:0] crm;
    int         gap;
    for (int i = 0; i < count; i++) begin
      wr  = 1'(pickBelow(2));
      crn = 4'(pickBelow(16));
      op2 = 3'(pickBelow(8));
      crm = 4'(pickBelow(16));
      gap = pickBelow(maxGap + 1);
      queueReq(toMmu, makeReq(wr, crn, op2, crm), gap);
    end
  endtask

  // Each port holds valid and payload until the ready edge
  task automatic driveCpu();
    while (cpuQ.size() > 0) begin
      repeat (cpuGapQ.pop_front()) @(negedge clk);
      cpuReq      = cpuQ.pop_front();
      cpuReqValid = 1'b1;
      @(posedge clk);
      while (!cpuReqReady) begin
        @(posedge clk);
      end
      @(negedge clk);
      cpuReqValid = 1'b0;
    end
  endtask

  task automatic driveMmu();
    while (mmuQ.size() > 0) begin
      repeat (mmuGapQ.pop_front()) @(negedge clk);
      mmuReq      = mmuQ.pop_front();
      mmuReqValid = 1'b1;
      @(posedge clk);
      while (!mmuReqReady) begin
        @(posedge clk);
      end
      @(negedge clk);
      mmuReqValid = 1'b0;
    end
  endtask

  // Three edges cover the last response after the fixed two-cycle latency
  task automatic drainPipe();
    repeat (3) @(negedge clk);
  endtask

  task automatic runQueued(string name);
    int expCpu;
    int expMmu;
    expCpu = cpuQ.size();
    expMmu = mmuQ.size();
    chk.startTest(name);
    fork
      driveCpu();
      driveMmu();
    join
    drainPipe();
    chk.endTest(expCpu, expMmu);
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin : mainSeq
    logic       wr;
    logic [3:0] crn;
    logic [2:0] op2;
    logic [3:0] crm;
    int         gap;

    reset       = 1'b1;
    cpuReqValid = 1'b0;
    mmuReqValid = 1'b0;
    cpuReq      = '0;
    mmuReq      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle cycles first and then c0 reads around a dropped c0 write
    queueReq(1'b0, makeReq(1'b0, 4'd0, 3'd0, 4'd0), 6);
    queueReq(1'b0, makeReq(1'b1, 4'd0, 3'd0, 4'd0), 0);
    queueReq(1'b1, makeReq(1'b0, 4'd0, 3'd0, 4'd0), 9);
    queueReq(1'b0, makeReq(1'b0, 4'd1, 3'd0, 4'd0), 2);
    queueReq(1'b0, makeReq(1'b0, 4'd2, 3'd0, 4'd0), 0);
    runQueued("resetState");

    fillRandom(1'b0, RAND_REQS, MAX_GAP);
    fillRandom(1'b1, RAND_REQS, MAX_GAP);
    runQueued("randomRdWr");

    for (int i = 0; i < CTRL_CPU_REQS + CTRL_MMU_REQS; i++) begin
      wr  = (pickBelow(4) != 0);
      crn = 4'(1 + pickBelow(2));
      gap = pickBelow(MAX_GAP + 1);
      queueReq(i >= CTRL_CPU_REQS, makeReq(wr, crn, 3'd0, 4'd0), gap);
    end
    runQueued("ctrlTbase");

    // CPU is always valid and only gets through in MMU gaps
    fillRandom(1'b1, COLL_REQS, 1);
    fillRandom(1'b0, COLL_REQS, 0);
    runQueued("collision");

    for (int i = 0; i < 2 * MAINT_REQS; i++) begin
      wr = (pickBelow(5) != 0);
      case (pickBelow(4))
        0:       crn = 4'(`CP15_REG_CACHE);
        1:       crn = 4'(`CP15_REG_TLB);
        default: crn = 4'(pickBelow(16));
      endcase
      op2 = (pickBelow(3) != 0) ? 3'(pickBelow(2)) : 3'(pickBelow(8));
      crm = 4'(pickBelow(16));
      gap = pickBelow(MAX_GAP + 1);
      queueReq((i % 2) == 1, makeReq(wr, crn, op2, crm), gap);
    end
    runQueued("maintOps");

    // Write then read of the same register with no gaps
    for (int i = 0; i < B2B_REQS; i++) begin
      if (i % 2 == 0) begin
        crn = 4'(pickBelow(16));
      end
      op2 = 3'(pickBelow(8));
      crm = 4'(pickBelow(16));
      queueReq(1'b0, makeReq(i % 2 == 0, crn, op2, crm), 0);
    end
    runQueued("backToBack");

    $display("Summary: %0d tests, %0d checks, %0d errors",
             chk.testCount, chk.checkCount, chk.errorCount);
    if (chk.errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+include
logic/cp15_pkg.sv
logic/cp15Arbiter.sv
logic/cp15RegFile.sv
logic/cp15MaintDecode.sv
logic/cp15Top.sv
verif/cp15Checker.sv
verif/cp15Tb.sv
